//--- logic/fifo_ctrl_fsm.sv
`timescale 1ns/1ps

module fifo_ctrl_fsm (
    input  logic           wr_clk,
    input  logic           rd_srst,

    // Requests
    input  logic           i_wr,
    input  logic           i_rd,
    input  logic           i_mem_rdy,

    // Write side
    output logic           o_wr_rdy,
    output logic           o_wr_safe,
    output fifo_pkg::ptr_t o_wr_ptr,
    output logic           o_full,
    output logic           o_wr_oflow,

    // Read side
    output fifo_pkg::ptr_t o_rd_ptr,
    output fifo_pkg::cnt_t o_count,
    output logic           o_rd_empty,
    output logic           o_rd_uflow
);
    import fifo_pkg::*;

    cnt_t wr_ptr_ext;
    cnt_t rd_ptr_ext;
    cnt_t level;
    logic rd_safe;

    // ------------------------------------------------------------------------
    // Pointers
    // ------------------------------------------------------------------------
    // Protected strobes, requests against the registered flags
    assign o_wr_safe = i_wr && o_wr_rdy;
    assign rd_safe   = i_rd && !o_rd_empty;

    always_ff @(posedge wr_clk) begin
        if (rd_srst)        wr_ptr_ext <= '0;
        else if (o_wr_safe) wr_ptr_ext <= wr_ptr_ext + 1'b1;
    end

    always_ff @(posedge wr_clk) begin
        if (rd_srst)      rd_ptr_ext <= '0;
        else if (rd_safe) rd_ptr_ext <= rd_ptr_ext + 1'b1;
    end

    // Storage addresses drop the wrap bit
    assign o_wr_ptr = wr_ptr_ext[PTR_WID-1:0];
    assign o_rd_ptr = rd_ptr_ext[PTR_WID-1:0];

    // Raw fill level, modulo arithmetic on the extended pointers
    assign level = wr_ptr_ext - rd_ptr_ext;

    // ------------------------------------------------------------------------
    // Write-side flags
    // ------------------------------------------------------------------------
    // A write is counted at once, a read frees space one cycle later
    always_ff @(posedge wr_clk) begin
        if (rd_srst)        o_full <= 1'b0;
        else if (o_wr_safe) o_full <= (level >= cnt_t'(FIFO_DEPTH - 1));
        else                o_full <= (level == cnt_t'(FIFO_DEPTH));
    end

    // Memory not ready holds off writes from the next cycle
    always_ff @(posedge wr_clk) begin
        if (rd_srst || !i_mem_rdy) begin
            o_wr_rdy <= 1'b0;
        end else if (o_wr_safe) begin
            o_wr_rdy <= (level < cnt_t'(FIFO_DEPTH - 1));
        end else begin
            o_wr_rdy <= (level < cnt_t'(FIFO_DEPTH));
        end
    end

    // ------------------------------------------------------------------------
    // Read-side flags
    // ------------------------------------------------------------------------
    // A pop is counted at once, a write shows up one cycle later
    always_ff @(posedge wr_clk) begin
        if (rd_srst)      o_count <= '0;
        else if (rd_safe) o_count <= level - 1'b1;
        else              o_count <= level;
    end

    always_ff @(posedge wr_clk) begin
        if (rd_srst)      o_rd_empty <= 1'b1;
        else if (rd_safe) o_rd_empty <= (level <= cnt_t'(1));
        else              o_rd_empty <= (level == '0);
    end

    // Dropped requests, one pulse per cycle of the request
    assign o_wr_oflow = i_wr && !o_wr_rdy;
    assign o_rd_uflow = i_rd && o_rd_empty;

endmodule : fifo_ctrl_fsm

//--- logic/fifo_mem.sv
`timescale 1ns/1ps

module fifo_mem (
    input  logic            wr_clk,

    // Write port
    input  logic            i_wr_en,
    input  fifo_pkg::ptr_t  i_wr_addr,
    input  fifo_pkg::data_t i_wr_data,

    // Read port
    input  fifo_pkg::ptr_t  i_rd_addr,
    output fifo_pkg::data_t o_rd_data
);
    import fifo_pkg::*;

    data_t mem [FIFO_DEPTH];

    // Synchronous write
    always_ff @(posedge wr_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // Head word, read without a clock
    assign o_rd_data = mem[i_rd_addr];

endmodule : fifo_mem

//--- logic/fifo_mon_regs.sv
`timescale 1ns/1ps

module fifo_mon_regs (
    input  logic              wr_clk,
    input  logic              rd_srst,

    // Wishbone classic slave
    input  logic              i_wb_cyc,
    input  logic              i_wb_stb,
    input  logic              i_wb_we,
    input  fifo_pkg::wb_adr_t i_wb_adr,
    input  fifo_pkg::wb_dat_t i_wb_dat,
    output fifo_pkg::wb_dat_t o_wb_dat,
    output logic              o_wb_ack,

    // FIFO state
    input  fifo_pkg::cnt_t    i_count,
    input  logic              i_full,
    input  logic              i_empty,
    input  logic              i_wr_rdy,
    input  logic              i_oflow,
    input  logic              i_uflow
);
    import fifo_pkg::*;

    wb_state_t state;
    wb_dat_t   rd_word;
    evt_cnt_t  oflow_cnt;
    evt_cnt_t  uflow_cnt;
    logic      req;
    logic      wr_req;
    logic      oflow_clr;
    logic      uflow_clr;

    // Next value of a saturating event counter, clear has priority
    function automatic evt_cnt_t evt_next(evt_cnt_t cnt, logic pulse, logic clr);
        if (clr)                       return '0;
        else if (pulse && (cnt != '1)) return cnt + 1'b1;
        else                           return cnt;
    endfunction

    // ------------------------------------------------------------------------
    // Bus handshake
    // ------------------------------------------------------------------------
    assign req    = (state == WB_IDLE) && i_wb_cyc && i_wb_stb;
    assign wr_req = req && i_wb_we;

    always_ff @(posedge wr_clk) begin
        if (rd_srst) begin
            state <= WB_IDLE;
        end else begin
            case (state)
                WB_IDLE: if (req) state <= WB_ACK;
                WB_ACK:  state <= WB_IDLE;
                default: state <= WB_IDLE;
            endcase
        end
    end

    // One cycle ack
    assign o_wb_ack = (state == WB_ACK);

    // ------------------------------------------------------------------------
    // Readback
    // ------------------------------------------------------------------------
    always_comb begin
        rd_word = '0;
        case (i_wb_adr)
            REG_INFO: begin
                rd_word[15:0] = 16'(FIFO_DEPTH);
                // Overflow/underflow protection always on
                rd_word[16]   = 1'b1;
            end
            REG_STATUS: rd_word[2:0]         = {i_wr_rdy, i_empty, i_full};
            REG_COUNT:  rd_word[CNT_WID-1:0] = i_count;
            REG_OFLOW:  rd_word[EVT_WID-1:0] = oflow_cnt;
            REG_UFLOW:  rd_word[EVT_WID-1:0] = uflow_cnt;
            default:    rd_word = '0;
        endcase
    end

    // Sampled on the edge that raises the ack
    always_ff @(posedge wr_clk) begin
        if (req) begin
            o_wb_dat <= rd_word;
        end
    end

    // ------------------------------------------------------------------------
    // Event counters
    // ------------------------------------------------------------------------
    // Write data is don't-care, any write clears
    assign oflow_clr = wr_req && (i_wb_adr == REG_OFLOW);
    assign uflow_clr = wr_req && (i_wb_adr == REG_UFLOW);

    always_ff @(posedge wr_clk) begin
        if (rd_srst) begin
            oflow_cnt <= '0;
            uflow_cnt <= '0;
        end else begin
            oflow_cnt <= evt_next(oflow_cnt, i_oflow, oflow_clr);
            uflow_cnt <= evt_next(uflow_cnt, i_uflow, uflow_clr);
        end
    end

endmodule : fifo_mon_regs

//--- logic/fifo_pkg.sv
package fifo_pkg;

    // ------------------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------------------
    localparam int FIFO_DEPTH = 16;
    localparam int PTR_WID    = $clog2(FIFO_DEPTH);
    // Extra bit so a count can reach FIFO_DEPTH
    localparam int CNT_WID    = $clog2(FIFO_DEPTH + 1);
    localparam int DATA_WID   = 16;
    localparam int EVT_WID    = 16;

    // Wishbone
    localparam int WB_ADR_WID = 3;
    localparam int WB_DAT_WID = 32;

    // ------------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------------
    typedef logic [PTR_WID-1:0]    ptr_t;
    typedef logic [CNT_WID-1:0]    cnt_t;
    typedef logic [DATA_WID-1:0]   data_t;
    typedef logic [WB_ADR_WID-1:0] wb_adr_t;
    typedef logic [WB_DAT_WID-1:0] wb_dat_t;
    typedef logic [EVT_WID-1:0]    evt_cnt_t;

    // Monitor register map (word addresses)
    localparam wb_adr_t REG_INFO   = 3'd0;
    localparam wb_adr_t REG_STATUS = 3'd1;
    localparam wb_adr_t REG_COUNT  = 3'd2;
    localparam wb_adr_t REG_OFLOW  = 3'd3;
    localparam wb_adr_t REG_UFLOW  = 3'd4;

    // Bus slave states
    typedef enum logic {
        WB_IDLE,
        WB_ACK
    } wb_state_t;

endpackage : fifo_pkg

//--- logic/fifo_top.sv
`timescale 1ns/1ps

module fifo_top (
    input  logic              wr_clk,
    input  logic              rd_srst,

    // Write port
    input  logic              i_wr,
    input  fifo_pkg::data_t   i_wr_data,
    input  logic              i_mem_rdy,
    output logic              o_wr_rdy,
    output logic              o_wr_oflow,

    // Read port
    input  logic              i_rd,
    output fifo_pkg::data_t   o_rd_data,
    output logic              o_rd_empty,
    output logic              o_rd_uflow,

    // Monitor bus
    input  logic              i_wb_cyc,
    input  logic              i_wb_stb,
    input  logic              i_wb_we,
    input  fifo_pkg::wb_adr_t i_wb_adr,
    input  fifo_pkg::wb_dat_t i_wb_dat,
    output fifo_pkg::wb_dat_t o_wb_dat,
    output logic              o_wb_ack
);
    import fifo_pkg::*;

    logic wr_safe;
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;
    logic full;

    fifo_ctrl_fsm fifo_ctrl_fsm_i (
        .wr_clk     (wr_clk),
        .rd_srst    (rd_srst),
        .i_wr       (i_wr),
        .i_rd       (i_rd),
        .i_mem_rdy  (i_mem_rdy),
        .o_wr_rdy   (o_wr_rdy),
        .o_wr_safe  (wr_safe),
        .o_wr_ptr   (wr_ptr),
        .o_full     (full),
        .o_wr_oflow (o_wr_oflow),
        .o_rd_ptr   (rd_ptr),
        .o_count    (count),
        .o_rd_empty (o_rd_empty),
        .o_rd_uflow (o_rd_uflow)
    );

    fifo_mem fifo_mem_i (
        .wr_clk    (wr_clk),
        .i_wr_en   (wr_safe),
        .i_wr_addr (wr_ptr),
        .i_wr_data (i_wr_data),
        .i_rd_addr (rd_ptr),
        .o_rd_data (o_rd_data)
    );

    fifo_mon_regs fifo_mon_regs_i (
        .wr_clk   (wr_clk),
        .rd_srst  (rd_srst),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack),
        .i_count  (count),
        .i_full   (full),
        .i_empty  (o_rd_empty),
        .i_wr_rdy (o_wr_rdy),
        .i_oflow  (o_wr_oflow),
        .i_uflow  (o_rd_uflow)
    );

endmodule : fifo_top

//--- tb/fifo_top_assertions.sv
`timescale 1ns/1ps

module fifo_top_assertions (
    input logic wr_clk,
    input logic rd_srst,
    input logic i_ack,
    input logic i_full,
    input logic i_empty,
    input logic i_wr_rdy
);

    // Ack is a single-cycle pulse
    ack_one_cycle: assert property (
        @(posedge wr_clk) disable iff (rd_srst) i_ack |=> !i_ack
    ) else $error("Wishbone ack held for more than one cycle");

    full_not_empty: assert property (
        @(posedge wr_clk) disable iff (rd_srst) !(i_full && i_empty)
    ) else $error("full and empty flags high together");

    // A full FIFO never offers write ready
    no_rdy_when_full: assert property (
        @(posedge wr_clk) disable iff (rd_srst) i_full |-> !i_wr_rdy
    ) else $error("write ready high while full");

endmodule : fifo_top_assertions

// Flags at their source, no bus here
bind fifo_ctrl_fsm fifo_top_assertions ctrl_assertions_i (
    .wr_clk   (wr_clk),
    .rd_srst  (rd_srst),
    .i_ack    (1'b0),
    .i_full   (o_full),
    .i_empty  (o_rd_empty),
    .i_wr_rdy (o_wr_rdy)
);

bind fifo_mon_regs fifo_top_assertions mon_assertions_i (
    .wr_clk   (wr_clk),
    .rd_srst  (rd_srst),
    .i_ack    (o_wb_ack),
    .i_full   (i_full),
    .i_empty  (i_empty),
    .i_wr_rdy (i_wr_rdy)
);

//--- tb/fifo_top_tb.sv
`timescale 1ns/1ps

module fifo_top_tb;
    import fifo_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_TESTS  = 6;
    localparam int ACK_LIMIT  = 8;

    logic    wr_clk;
    logic    rd_srst;
    logic    i_wr;
    data_t   i_wr_data;
    logic    i_rd;
    logic    i_mem_rdy;
    logic    o_wr_rdy;
    logic    o_wr_oflow;
    data_t   o_rd_data;
    logic    o_rd_empty;
    logic    o_rd_uflow;
    logic    i_wb_cyc;
    logic    i_wb_stb;
    logic    i_wb_we;
    wb_adr_t i_wb_adr;
    wb_dat_t i_wb_dat;
    wb_dat_t o_wb_dat;
    logic    o_wb_ack;

    integer  seed = 32'hf586;
    // Reference model, one entry per accepted word
    data_t   model[$];

    fifo_top fifo_top_i (.*);

    initial begin
        wr_clk = 1'b0;
        forever #(CLK_PERIOD / 2) wr_clk = ~wr_clk;
    end

    // Watchdog, 400 cycles per test
    initial begin
        #(NUM_TESTS * 400 * CLK_PERIOD);
        abort_run("watchdog timeout, the tests did not finish in time");
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s, got %h expected %h",
                                $time, what, got, exp));
    endtask

    task automatic check_count(input cnt_t got, input cnt_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s, got %0d expected %0d",
                                $time, what, got, exp));
    endtask

    task automatic check_reg(input wb_dat_t got, input wb_dat_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s, got %h expected %h",
                                $time, what, got, exp));
    endtask

    task automatic check_flag(input bit got, input bit exp, input string what);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s, got %b expected %b",
                                $time, what, got, exp));
    endtask

    // ------------------------------------------------------------------------
    // Drivers, all called at a falling edge
    // ------------------------------------------------------------------------
    task automatic idle(input int n);
        repeat (n) @(negedge wr_clk);
    endtask

    // One cycle of requests, model follows the acceptance rules
    task automatic drive_cycle(input bit wr, input data_t d, input bit rd);
        bit rdy_seen;
        bit empty_seen;
        rdy_seen   = o_wr_rdy;
        empty_seen = o_rd_empty;
        i_wr      = wr;
        i_wr_data = d;
        i_rd      = rd;
        if (rd && !empty_seen) begin
            if (model.size() == 0)
                abort_run("the FIFO offered a word while the model was empty");
            check_data(o_rd_data, model.pop_front(), "popped word");
        end
        if (wr && rdy_seen)
            model.push_back(d);
        #1;
        check_flag(o_wr_oflow, wr && !rdy_seen, "overflow pulse");
        check_flag(o_rd_uflow, rd && empty_seen, "underflow pulse");
        @(negedge wr_clk);
        i_wr = 1'b0;
        i_rd = 1'b0;
    endtask

    task automatic bus_release();
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
    endtask

    task automatic wait_ack(input string what);
        int n;
        n = 0;
        @(negedge wr_clk);
        while (!o_wb_ack && n < ACK_LIMIT) begin
            @(negedge wr_clk);
            n++;
        end
        if (!o_wb_ack)
            abort_run($sformatf("no Wishbone ack within %0d cycles for %s", ACK_LIMIT, what));
    endtask

    task automatic wb_read(input wb_adr_t adr, output wb_dat_t dat);
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = 1'b0;
        i_wb_adr = adr;
        wait_ack("a register read");
        dat = o_wb_dat;
        bus_release();
    endtask

    task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat);
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = 1'b1;
        i_wb_adr = adr;
        i_wb_dat = dat;
        wait_ack("a register write");
        bus_release();
    endtask

    task automatic read_reg_check(input wb_adr_t adr, input wb_dat_t exp, input string what);
        wb_dat_t d;
        wb_read(adr, d);
        check_reg(d, exp, what);
    endtask

    // Idle cycle first so a recent write has reached the count
    task automatic count_matches(input string what);
        wb_dat_t d;
        idle(1);
        wb_read(REG_COUNT, d);
        check_count(cnt_t'(d), cnt_t'(model.size()), what);
    endtask

    task automatic drain_all(input string what);
        idle(1);
        while (model.size() > 0) begin
            check_flag(o_rd_empty, 1'b0, what);
            drive_cycle(1'b0, '0, 1'b1);
        end
        check_flag(o_rd_empty, 1'b1, {what, ", empty at the end"});
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic verify_reset_state();
        check_flag(o_rd_empty, 1'b1, "empty after reset");
        check_flag(o_wb_ack, 1'b0, "ack after reset");
        check_flag(o_wr_rdy, 1'b0, "ready at release");
        idle(1);
        check_flag(o_wr_rdy, 1'b1, "ready one edge after release");
        read_reg_check(REG_INFO, (wb_dat_t'(1) << 16) | wb_dat_t'(FIFO_DEPTH), "info word");
        read_reg_check(REG_STATUS, wb_dat_t'(3'b110), "status after reset");
        read_reg_check(REG_COUNT, '0, "count after reset");
        read_reg_check(REG_OFLOW, '0, "overflow events after reset");
        read_reg_check(REG_UFLOW, '0, "underflow events after reset");
        read_reg_check(wb_adr_t'(7), '0, "unmapped address");
    endtask

    task automatic order_and_latency();
        for (int i = 0; i < 5; i++) begin
            drive_cycle(1'b1, data_t'($random(seed)), 1'b0);
            if (i == 0) begin
                check_flag(o_rd_empty, 1'b1, "empty on the edge of the first write");
                idle(1);
                check_flag(o_rd_empty, 1'b0, "empty one edge after the first write");
            end
            count_matches("count while writing");
        end
        while (model.size() > 0) begin
            check_flag(o_rd_empty, 1'b0, "empty while words remain");
            drive_cycle(1'b0, '0, 1'b1);
            count_matches("count while reading");
        end
    endtask

    task automatic fill_and_overflow();
        int n;
        wb_write(REG_OFLOW, wb_dat_t'($random(seed)));
        n = 0;
        while (o_wr_rdy && n < FIFO_DEPTH + 4) begin
            drive_cycle(1'b1, data_t'($random(seed)), 1'b0);
            n++;
        end
        check_count(cnt_t'(n), cnt_t'(FIFO_DEPTH), "words accepted before full");
        repeat (3) drive_cycle(1'b1, data_t'($random(seed)), 1'b0);
        check_count(cnt_t'(model.size()), cnt_t'(FIFO_DEPTH), "words held after overflow");
        read_reg_check(REG_OFLOW, 3, "overflow events");
        read_reg_check(REG_STATUS, wb_dat_t'(3'b001), "status when full");
        // Space freed by a pop shows on the write side one edge later
        drive_cycle(1'b0, '0, 1'b1);
        check_flag(o_wr_rdy, 1'b0, "ready on the edge of the first pop");
        idle(1);
        check_flag(o_wr_rdy, 1'b1, "ready one edge after the first pop");
        drain_all("drain after overflow");
    endtask

    task automatic underflow_and_clear();
        wb_write(REG_UFLOW, wb_dat_t'($random(seed)));
        check_flag(o_rd_empty, 1'b1, "empty before empty reads");
        repeat (4) drive_cycle(1'b0, '0, 1'b1);
        count_matches("count after empty reads");
        read_reg_check(REG_UFLOW, 4, "underflow events");
        wb_write(REG_UFLOW, wb_dat_t'($random(seed)));
        read_reg_check(REG_UFLOW, '0, "underflow events after clear");
    endtask

    task automatic mem_ready_gating();
        wb_write(REG_OFLOW, wb_dat_t'($random(seed)));
        i_mem_rdy = 1'b0;
        idle(1);
        check_flag(o_wr_rdy, 1'b0, "ready one edge after memory not ready");
        repeat (3) drive_cycle(1'b1, data_t'($random(seed)), 1'b0);
        check_count(cnt_t'(model.size()), '0, "words held while memory not ready");
        read_reg_check(REG_OFLOW, 3, "overflows while memory not ready");
        i_mem_rdy = 1'b1;
        idle(1);
        check_flag(o_wr_rdy, 1'b1, "ready after memory ready");
        repeat (2) drive_cycle(1'b1, data_t'($random(seed)), 1'b0);
        check_count(cnt_t'(model.size()), 2, "words accepted after memory ready");
        drain_all("drain after memory ready");
    endtask

    task automatic random_streaming();
        bit wr;
        bit rd;
        for (int i = 0; i < 200; i++) begin
            // Writes lead in the first half so the FIFO reaches full
            if (i < 100)
                wr = (($random(seed) & 3) != 0);
            else
                wr = (($random(seed) & 3) == 0);
            rd = bit'($random(seed));
            drive_cycle(wr, data_t'($random(seed)), rd);
        end
        count_matches("count after streaming");
        drain_all("drain after streaming");
    endtask

    initial begin
        rd_srst   = 1'b1;
        i_wr      = 1'b0;
        i_wr_data = '0;
        i_rd      = 1'b0;
        i_mem_rdy = 1'b1;
        i_wb_adr  = '0;
        i_wb_dat  = '0;
        bus_release();
        repeat (3) @(posedge wr_clk);
        @(negedge wr_clk);
        rd_srst = 1'b0;

        verify_reset_state();
        order_and_latency();
        fill_and_overflow();
        underflow_and_clear();
        mem_ready_gating();
        random_streaming();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule : fifo_top_tb

//--- verilog.f
logic/fifo_pkg.sv
logic/fifo_ctrl_fsm.sv
logic/fifo_mem.sv
logic/fifo_mon_regs.sv
logic/fifo_top.sv
tb/fifo_top_assertions.sv
tb/fifo_top_tb.sv
